// File: design/img_load_pkg.sv
package img_load_pkg;

    // receiver register map in avalon byte addresses.
    localparam logic [4:0] rx_base     = 5'd0;
    localparam logic [4:0] status_base = 5'd8;

    // status register bit for receive ready.
    localparam int rx_ok_bit = 7;

    // one pixel is three received bytes.
    localparam int pixel_w = 24;

    // polling controller states.
    typedef enum logic [1:0] {
        st_idle,
        st_check,
        st_trans
    } ctrl_state_t;

endpackage

// File: design/uart_poll_ctrl.sv
`timescale 1ns/1ns

module uart_poll_ctrl (
    input  logic        avm_clk,
    input  logic        avm_rst_n,
    input  logic        start,
    input  logic        frame_done,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    input  logic        avm_waitrequest,
    output logic        byte_valid,
    output logic [7:0]  byte_data,
    output logic        busy
);

    img_load_pkg::ctrl_state_t state_r, state_w;

    logic [4:0] avm_address_r, avm_address_w;
    logic       avm_read_r, avm_read_w;
    logic       byte_valid_r, byte_valid_w;
    logic [7:0] byte_data_r, byte_data_w;
    logic       stop_r, stop_w;
    logic       rd_accept;
    logic       stop_now;

    assign avm_address = avm_address_r;
    assign avm_read    = avm_read_r;
    assign byte_valid  = byte_valid_r;
    assign byte_data   = byte_data_r;
    assign busy        = (state_r != img_load_pkg::st_idle);

    // a read completes when it is not stalled.
    assign rd_accept = avm_read_r && !avm_waitrequest;

    // frame end may arrive while a status read is still outstanding.
    assign stop_now = stop_r || frame_done;

    always_comb begin
        state_w       = state_r;
        avm_address_w = avm_address_r;
        avm_read_w    = avm_read_r;
        byte_valid_w  = 1'b0;
        byte_data_w   = byte_data_r;
        stop_w        = stop_r;

        case (state_r)
            img_load_pkg::st_idle: begin
                stop_w        = 1'b0;
                avm_read_w    = 1'b0;
                avm_address_w = img_load_pkg::status_base;
                if (start) begin
                    state_w    = img_load_pkg::st_check;
                    avm_read_w = 1'b1;
                end
            end
            img_load_pkg::st_check: begin
                stop_w = stop_now;
                if (stop_now) begin
                    // let the pending read finish first.
                    if (!avm_read_r || rd_accept) begin
                        state_w       = img_load_pkg::st_idle;
                        avm_read_w    = 1'b0;
                        avm_address_w = img_load_pkg::status_base;
                        stop_w        = 1'b0;
                    end
                end else if (!avm_read_r) begin
                    avm_read_w    = 1'b1;
                    avm_address_w = img_load_pkg::status_base;
                end else if (rd_accept && avm_readdata[img_load_pkg::rx_ok_bit]) begin
                    state_w       = img_load_pkg::st_trans;
                    avm_read_w    = 1'b0;
                    avm_address_w = img_load_pkg::rx_base;
                end
                // when not ready the status read just repeats.
            end
            img_load_pkg::st_trans: begin
                stop_w = stop_now;
                if (!avm_read_r) begin
                    avm_read_w    = 1'b1;
                    avm_address_w = img_load_pkg::rx_base;
                end else if (rd_accept) begin
                    state_w      = img_load_pkg::st_check;
                    avm_read_w   = 1'b0;
                    byte_valid_w = 1'b1;
                    byte_data_w  = avm_readdata[7:0];
                end
            end
            default: begin
                state_w       = img_load_pkg::st_idle;
                avm_read_w    = 1'b0;
                avm_address_w = img_load_pkg::status_base;
                stop_w        = 1'b0;
            end
        endcase
    end

    always_ff @(posedge avm_clk or negedge avm_rst_n) begin
        if (!avm_rst_n) begin
            state_r       <= img_load_pkg::st_idle;
            avm_address_r <= img_load_pkg::status_base;
            avm_read_r    <= 1'b0;
            byte_valid_r  <= 1'b0;
            stop_r        <= 1'b0;
        end else begin
            state_r       <= state_w;
            avm_address_r <= avm_address_w;
            avm_read_r    <= avm_read_w;
            byte_valid_r  <= byte_valid_w;
            stop_r        <= stop_w;
        end
    end

    always_ff @(posedge avm_clk) begin
        byte_data_r <= byte_data_w;
    end

endmodule

// File: design/pixel_assembler.sv
`timescale 1ns/1ns

module pixel_assembler #(
    parameter int frame_pixels = 64,
    parameter int addr_w       = 6
) (
    input  logic                             avm_clk,
    input  logic                             avm_rst_n,
    input  logic                             byte_valid,
    input  logic [7:0]                       byte_data,
    output logic                             wr_en,
    output logic [addr_w-1:0]                wr_addr,
    output logic [img_load_pkg::pixel_w-1:0] wr_data,
    output logic                             frame_done
);

    logic [1:0]                       byte_cnt_r;
    logic [7:0]                       hi_byte_r;
    logic [7:0]                       mid_byte_r;
    logic [addr_w-1:0]                pix_addr_r;
    logic                             wr_en_r;
    logic                             frame_done_r;
    logic [addr_w-1:0]                wr_addr_r;
    logic [img_load_pkg::pixel_w-1:0] wr_data_r;
    logic                             last_byte;
    logic                             last_pixel;

    assign wr_en      = wr_en_r;
    assign wr_addr    = wr_addr_r;
    assign wr_data    = wr_data_r;
    assign frame_done = frame_done_r;

    // third byte of a pixel completes it.
    assign last_byte  = byte_valid && (byte_cnt_r == 2'd2);
    assign last_pixel = (pix_addr_r == addr_w'(frame_pixels - 1));

    always_ff @(posedge avm_clk or negedge avm_rst_n) begin
        if (!avm_rst_n) begin
            byte_cnt_r   <= 2'd0;
            pix_addr_r   <= '0;
            wr_en_r      <= 1'b0;
            frame_done_r <= 1'b0;
        end else begin
            wr_en_r      <= last_byte;
            frame_done_r <= last_byte && last_pixel;

            if (byte_valid) begin
                if (last_byte) begin
                    byte_cnt_r <= 2'd0;
                end else begin
                    byte_cnt_r <= byte_cnt_r + 2'd1;
                end
            end

            // wrap to 0 after the last pixel of the frame.
            if (last_byte) begin
                if (last_pixel) begin
                    pix_addr_r <= '0;
                end else begin
                    pix_addr_r <= pix_addr_r + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (byte_valid) begin
            if (byte_cnt_r == 2'd0) begin
                hi_byte_r <= byte_data;
            end else if (byte_cnt_r == 2'd1) begin
                mid_byte_r <= byte_data;
            end
        end

        // first byte lands in the top of the pixel.
        if (last_byte) begin
            wr_addr_r <= pix_addr_r;
            wr_data_r <= {hi_byte_r, mid_byte_r, byte_data};
        end
    end

endmodule

// File: design/frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer #(
    parameter int frame_pixels = 64,
    parameter int addr_w       = 6
) (
    input  logic                             avm_clk,
    input  logic                             wr_en,
    input  logic [addr_w-1:0]                wr_addr,
    input  logic [img_load_pkg::pixel_w-1:0] wr_data,
    input  logic [addr_w-1:0]                rd_addr,
    output logic [img_load_pkg::pixel_w-1:0] rd_data
);

    logic [img_load_pkg::pixel_w-1:0] mem [frame_pixels];
    logic [img_load_pkg::pixel_w-1:0] rd_data_r;

    assign rd_data = rd_data_r;

    // write port.
    always_ff @(posedge avm_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read data is registered one cycle after rd_addr.
    always_ff @(posedge avm_clk) begin
        rd_data_r <= mem[rd_addr];
    end

endmodule

// File: design/image_loader_top.sv
`timescale 1ns/1ns

module image_loader_top #(
    parameter int frame_pixels = 64,
    parameter int addr_w       = 6
) (
    input  logic                             avm_clk,
    input  logic                             avm_rst_n,
    input  logic                             start,
    output logic [4:0]                       avm_address,
    output logic                             avm_read,
    input  logic [31:0]                      avm_readdata,
    input  logic                             avm_waitrequest,
    output logic                             busy,
    output logic                             frame_done,
    input  logic [addr_w-1:0]                rd_addr,
    output logic [img_load_pkg::pixel_w-1:0] rd_data
);

    logic                             byte_valid;
    logic [7:0]                       byte_data;
    logic                             wr_en;
    logic [addr_w-1:0]                wr_addr;
    logic [img_load_pkg::pixel_w-1:0] wr_data;

    uart_poll_ctrl u_uart_poll_ctrl (
        .avm_clk         (avm_clk),
        .avm_rst_n       (avm_rst_n),
        .start           (start),
        .frame_done      (frame_done),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest),
        .byte_valid      (byte_valid),
        .byte_data       (byte_data),
        .busy            (busy)
    );

    pixel_assembler #(
        .frame_pixels (frame_pixels),
        .addr_w       (addr_w)
    ) u_pixel_assembler (
        .avm_clk    (avm_clk),
        .avm_rst_n  (avm_rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .frame_done (frame_done)
    );

    frame_buffer #(
        .frame_pixels (frame_pixels),
        .addr_w       (addr_w)
    ) u_frame_buffer (
        .avm_clk (avm_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 8
) (
    output logic avm_clk,
    output logic avm_rst_n
);

    initial begin
        avm_clk = 1'b0;
        forever begin
            #(half_period) avm_clk = ~avm_clk;
        end
    end

    // reset is released on a falling edge.
    initial begin
        avm_rst_n = 1'b0;
        repeat (reset_cycles) @(posedge avm_clk);
        @(negedge avm_clk);
        avm_rst_n = 1'b1;
    end

endmodule

// File: dv/uart_slave_model.sv
`timescale 1ns/1ns

module uart_slave_model (
    input  logic        avm_clk,
    input  logic        avm_rst_n,
    input  logic [4:0]  avm_address,
    input  logic        avm_read,
    output logic [31:0] avm_readdata,
    output logic        avm_waitrequest,
    input  logic        push_valid,
    input  logic [7:0]  push_data,
    input  logic        stall_req
);

    logic [7:0] rx_q [$];
    logic       rx_avail_r;
    logic [7:0] rx_head_r;
    logic       rd_accept;

    // stall only matters while a read is pending.
    assign avm_waitrequest = avm_read && stall_req;
    assign rd_accept       = avm_read && !avm_waitrequest;

    always_comb begin
        avm_readdata = 32'h0;
        if (avm_address == img_load_pkg::status_base) begin
            avm_readdata[img_load_pkg::rx_ok_bit] = rx_avail_r;
        end else if (avm_address == img_load_pkg::rx_base) begin
            avm_readdata[7:0] = rx_head_r;
        end
    end

    // queue state is mirrored into registers so readdata only changes after the edge.
    always @(posedge avm_clk or negedge avm_rst_n) begin
        if (!avm_rst_n) begin
            rx_q.delete();
            rx_avail_r <= 1'b0;
            rx_head_r  <= 8'h00;
        end else begin
            if (rd_accept && avm_address == img_load_pkg::rx_base && rx_q.size() > 0) begin
                void'(rx_q.pop_front());
            end
            if (push_valid) begin
                rx_q.push_back(push_data);
            end
            rx_avail_r <= (rx_q.size() != 0);
            if (rx_q.size() != 0) begin
                rx_head_r <= rx_q[0];
            end
        end
    end

endmodule

// File: dv/image_loader_tb.sv
`timescale 1ns/1ns

module image_loader_tb;

    localparam int frame_pixels = 16;
    localparam int addr_w       = 4;
    localparam int frame_bytes  = frame_pixels * 3;
    localparam int wait_limit   = 5000;

    logic              avm_clk;
    logic              avm_rst_n;
    logic              start;
    logic [4:0]        avm_address;
    logic              avm_read;
    logic [31:0]       avm_readdata;
    logic              avm_waitrequest;
    logic              busy;
    logic              frame_done;
    logic [addr_w-1:0] rd_addr;
    logic [23:0]       rd_data;
    logic              push_valid;
    logic [7:0]        push_data;
    logic              stall_req = 1'b0;

    logic [31:0] rng_state = 32'hbbace1c9;
    logic [31:0] stall_rnd = 32'hbbace1c9;
    logic [7:0]  sent_bytes [frame_bytes];
    int          error_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;
    int          protocol_errors = 0;
    int          status_reads = 0;
    int          rx_reads = 0;
    int          frame_count = 0;
    int          stall_count = 0;
    logic        status_ok = 1'b0;
    logic        stall_seen = 1'b0;
    logic [4:0]  held_addr = 5'd0;

    tb_clock_gen u_tb_clock_gen (
        .avm_clk   (avm_clk),
        .avm_rst_n (avm_rst_n)
    );

    image_loader_top #(
        .frame_pixels (frame_pixels),
        .addr_w       (addr_w)
    ) u_image_loader_top (
        .avm_clk         (avm_clk),
        .avm_rst_n       (avm_rst_n),
        .start           (start),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest),
        .busy            (busy),
        .frame_done      (frame_done),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data)
    );

    uart_slave_model u_uart_slave_model (
        .avm_clk         (avm_clk),
        .avm_rst_n       (avm_rst_n),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest),
        .push_valid      (push_valid),
        .push_data       (push_data),
        .stall_req       (stall_req)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAIL %0t ns %s: expected %h, got %h", $time, name, exp, got);
        error_count++;
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic protocol_error(input string msg);
        protocol_errors++;
        report_error(msg);
    endtask

    task automatic finish_test(input string name, input int new_errors);
        test_count++;
        if (new_errors > 0) begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, new_errors);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge avm_clk);
        start = 1'b0;
    endtask

    // random bytes with random gaps and optional start pulses mid-frame.
    task automatic send_frame(input bit extra_starts);
        logic [31:0] r;
        int          i;
        for (i = 0; i < frame_bytes; i++) begin
            next_rand(r);
            sent_bytes[i] = r[7:0];
            next_rand(r);
            repeat (r[1:0]) @(negedge avm_clk);
            push_valid = 1'b1;
            push_data  = sent_bytes[i];
            start      = extra_starts && (i == 8 || i == 30);
            @(negedge avm_clk);
            push_valid = 1'b0;
            start      = 1'b0;
        end
    endtask

    task automatic wait_frame_done(input int count_before);
        int n;
        n = 0;
        while (frame_count == count_before && n < wait_limit) begin
            @(negedge avm_clk);
            n++;
        end
        assert (frame_count != count_before)
            else report_error("timed out waiting for frame_done");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0 && n < wait_limit) begin
            @(negedge avm_clk);
            n++;
        end
        assert (busy === 1'b0)
            else report_error("timed out waiting for busy to fall");
    endtask

    // expected pixel holds three bytes in arrival order with the first on top.
    task automatic check_frame();
        logic [23:0] expected;
        int          a;
        for (a = 0; a < frame_pixels; a++) begin
            rd_addr = addr_w'(a);
            @(negedge avm_clk);
            expected = {sent_bytes[3*a], sent_bytes[3*a+1], sent_bytes[3*a+2]};
            assert (rd_data === expected)
                else report_mismatch($sformatf("rd_data[%0d]", a), 32'(expected),
                                     32'(rd_data));
        end
    endtask

    // waitrequest draws on its own xorshift stream.
    always @(negedge avm_clk) begin
        stall_rnd = xorshift32(stall_rnd);
        stall_req = (stall_rnd[2:0] < 3'd3);
    end

    // the bus monitor sees the values that were stable before the edge.
    always @(posedge avm_clk) begin
        if (avm_rst_n) begin
            if (stall_seen) begin
                assert (avm_read === 1'b1 && avm_address === held_addr)
                    else protocol_error("avm_read or avm_address changed during waitrequest");
            end
            stall_seen = avm_read && avm_waitrequest;
            held_addr  = avm_address;
            if (avm_waitrequest) begin
                stall_count++;
            end
            if (avm_read && !avm_waitrequest) begin
                if (avm_address == img_load_pkg::status_base) begin
                    status_reads++;
                    status_ok = avm_readdata[img_load_pkg::rx_ok_bit];
                end else if (avm_address == img_load_pkg::rx_base) begin
                    rx_reads++;
                    assert (status_ok)
                        else protocol_error("rx_base read without a ready status read first");
                    status_ok = 1'b0;
                end
            end
            if (frame_done) begin
                frame_count++;
            end
        end
    end

    initial begin
        #1000000;
        $display("watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int errs_before;
        int frames_before;
        int status_before;
        int i;

        start      = 1'b0;
        rd_addr    = '0;
        push_valid = 1'b0;
        push_data  = 8'h00;

        for (i = 0; i < 100 && avm_rst_n !== 1'b1; i++) begin
            @(negedge avm_clk);
        end
        @(negedge avm_clk);

        errs_before = error_count;
        assert (avm_rst_n === 1'b1) else report_error("reset was never released");
        assert (avm_read === 1'b0) else report_mismatch("avm_read", 0, avm_read);
        assert (busy === 1'b0) else report_mismatch("busy", 0, busy);
        assert (frame_done === 1'b0) else report_mismatch("frame_done", 0, frame_done);
        assert (avm_address === img_load_pkg::status_base)
            else report_mismatch("avm_address", img_load_pkg::status_base, avm_address);
        repeat (10) @(negedge avm_clk);
        assert (status_reads == 0 && rx_reads == 0)
            else report_error("bus read seen before start");
        finish_test("reset_state", error_count - errs_before);

        // with an empty queue the controller may only poll status.
        errs_before   = error_count;
        status_before = status_reads;
        pulse_start();
        for (i = 0; i < 40; i++) begin
            @(negedge avm_clk);
            assert (busy === 1'b1) else report_mismatch("busy", 1, busy);
        end
        assert (status_reads > status_before)
            else report_error("no status polling while waiting for data");
        assert (rx_reads == 0) else report_mismatch("rx_reads", 0, rx_reads);
        finish_test("no_premature_reads", error_count - errs_before);

        errs_before   = error_count;
        frames_before = frame_count;
        send_frame(1'b0);
        wait_frame_done(frames_before);
        wait_idle();
        repeat (5) @(negedge avm_clk);
        assert (frame_count == frames_before + 1)
            else report_mismatch("frame_done pulses", 1, frame_count - frames_before);
        assert (rx_reads == frame_bytes) else report_mismatch("rx_reads", frame_bytes, rx_reads);
        check_frame();
        finish_test("frame_load", error_count - errs_before);

        errs_before   = error_count;
        frames_before = frame_count;
        pulse_start();
        send_frame(1'b1);
        wait_frame_done(frames_before);
        wait_idle();
        repeat (5) @(negedge avm_clk);
        assert (frame_count == frames_before + 1)
            else report_mismatch("frame_done pulses", 1, frame_count - frames_before);
        assert (busy === 1'b0) else report_mismatch("busy", 0, busy);
        check_frame();
        finish_test("second_frame", error_count - errs_before);

        errs_before = error_count;
        assert (stall_count > 0) else report_error("no waitrequest cycles were seen");
        finish_test("bus_protocol", protocol_errors + error_count - errs_before);

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
design/img_load_pkg.sv
design/uart_poll_ctrl.sv
design/pixel_assembler.sv
design/frame_buffer.sv
design/image_loader_top.sv
dv/tb_clock_gen.sv
dv/uart_slave_model.sv
dv/image_loader_tb.sv
